// ==== compile.f ====
hw/audio_pkg.sv
hw/audio_ctrl_if.sv
hw/spi_reg_decode.sv
hw/i2s_rx.sv
hw/gain_stage.sv
hw/i2s_tx.sv
hw/audipus_core.sv
dv/audipus_tb.sv

// ==== Makefile ====
TOP = audipus_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/audipus_tb.sv ====
`timescale 1ns/1ps

module audipus_tb;
    import audio_pkg::*;

    // clocks per i2s frame: 32 bclk of 8 clk
    localparam int frame_clk = 256;
    // one spi frame: 16 bits of 16 clk plus cs setup and hold
    localparam int spi_frame_clk = 16 * 16 + 32;
    localparam int n_fixed = 9;
    localparam int n_random = 4;
    localparam int n_rows = n_fixed + n_random;
    // per row: 3 writes, 1 read, at most 6 frames of waiting
    localparam int row_clk = 6 * frame_clk + 4 * spi_frame_clk;
    localparam int cycle_limit = n_rows * row_clk + 14 * spi_frame_clk
                               + 6 * frame_clk + 2000;

    typedef struct packed {
        logic [7:0]         control;
        logic [7:0]         gain_left;
        logic [7:0]         gain_right;
        logic signed [15:0] in_left;
        logic signed [15:0] in_right;
        logic signed [15:0] exp_left;
        logic signed [15:0] exp_right;
        logic               clip;
    } row_t;

    logic clk = 1'b0;
    logic reset;
    logic spi_cs_n;
    logic spi_clk;
    logic spi_mosi;
    logic spi_miso;
    logic i2s_bclk;
    logic i2s_lrclk;
    logic i2s_d;
    logic dac_bclk;
    logic dac_lrclk;
    logic dac_data;

    row_t rows [n_rows];
    int   error_count = 0;
    int   cycle_count = 0;

    // words the i2s source sends next frame
    logic signed [15:0] src_left;
    logic signed [15:0] src_right;

    // sink state and last decoded pair
    logic               sink_bclk_last = 1'b0;
    logic               sink_lr_last = 1'b0;
    logic [15:0]        sink_sr = '0;
    logic [15:0]        sink_left = '0;
    logic signed [15:0] got_left = '0;
    logic signed [15:0] got_right = '0;
    int                 pair_count = 0;

    audipus_core audipus_core_i (
        .clk       (clk),
        .reset     (reset),
        .spi_cs_n  (spi_cs_n),
        .spi_clk   (spi_clk),
        .spi_mosi  (spi_mosi),
        .spi_miso  (spi_miso),
        .i2s_bclk  (i2s_bclk),
        .i2s_lrclk (i2s_lrclk),
        .i2s_d     (i2s_d),
        .dac_bclk  (dac_bclk),
        .dac_lrclk (dac_lrclk),
        .dac_data  (dac_data)
    );

    always #10 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("simulation timed out after %0d clock cycles", cycle_count);
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // i2s source and sink
    //////////////////////////////////////////////////////////////////////

    // bclk low for phases 0..3, high for 4..7
    initial begin
        int          slot;
        int          phase;
        logic [31:0] src_sr;
        slot = 0;
        phase = 0;
        src_sr = '0;
        i2s_bclk = 1'b0;
        i2s_lrclk = 1'b0;
        i2s_d = 1'b0;
        forever begin
            @(posedge clk);
            if (phase == 0) begin
                i2s_bclk <= 1'b0;
                i2s_lrclk <= (slot >= 16);
                // slot 0 still carries the lsb of the last right word
                i2s_d <= src_sr[31];
                if (slot == 0) begin
                    src_sr = {src_left, src_right};
                end else begin
                    src_sr = src_sr << 1;
                end
            end else if (phase == 4) begin
                i2s_bclk <= 1'b1;
            end
            phase = (phase + 1) % 8;
            if (phase == 0) begin
                slot = (slot + 1) % 32;
            end
        end
    end

    // decode dac lines, lsb lands on the first rise after the lr edge
    always @(posedge clk) begin
        logic [15:0] word;
        word = {sink_sr[14:0], dac_data};
        sink_bclk_last <= dac_bclk;
        if (dac_bclk && !sink_bclk_last) begin
            sink_sr <= word;
            sink_lr_last <= dac_lrclk;
            if (dac_lrclk != sink_lr_last) begin
                if (sink_lr_last) begin
                    got_left <= sink_left;
                    got_right <= word;
                    pair_count <= pair_count + 1;
                end else begin
                    sink_left <= word;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_equal(input int actual, input int expected, input string what);
        if (actual != expected) begin
            error_count++;
            $display("FAILED at %0d ns: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "first mismatch");
        end
    endtask

    // mode 0, 16 clk per spi bit
    task automatic spi_frame(input logic [15:0] frame, output logic [7:0] rdata);
        rdata = '0;
        @(posedge clk);
        spi_cs_n <= 1'b0;
        for (int i = 15; i >= 0; i--) begin
            spi_mosi <= frame[i];
            repeat (8) @(posedge clk);
            spi_clk <= 1'b1;
            if (i < 8) begin
                rdata[i] = spi_miso;
            end
            repeat (8) @(posedge clk);
            spi_clk <= 1'b0;
        end
        repeat (8) @(posedge clk);
        spi_cs_n <= 1'b1;
        repeat (8) @(posedge clk);
    endtask

    task automatic write_reg(input logic [6:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        spi_frame({1'b0, addr, data}, unused);
    endtask

    task automatic read_reg(input logic [6:0] addr, output logic [7:0] data);
        spi_frame({1'b1, addr, 8'h00}, data);
    endtask

    task automatic wait_pairs(input int n);
        int target;
        target = pair_count + n;
        while (pair_count < target) begin
            @(posedge clk);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // q1.7 gain, floor shift, clamp to 16 bits
    function automatic int scaled_sample(input int sample, input int gain);
        int p;
        p = (sample * gain) >>> 7;
        if (p > 32767) begin
            return 32767;
        end else if (p < -32768) begin
            return -32768;
        end
        return p;
    endfunction

    function automatic bit clips(input int sample, input int gain);
        int p;
        p = (sample * gain) >>> 7;
        return (p > 32767) || (p < -32768);
    endfunction

    // program, flush with zeros, play the row, check third pair and status
    task automatic run_row(input int r);
        logic [7:0] rd;
        wait_pairs(1);
        src_left <= '0;
        src_right <= '0;
        write_reg(reg_gain_left, rows[r].gain_left);
        write_reg(reg_gain_right, rows[r].gain_right);
        write_reg(reg_control, rows[r].control);
        wait_pairs(1);
        src_left <= rows[r].in_left;
        src_right <= rows[r].in_right;
        wait_pairs(3);
        check_equal(got_left, $signed(rows[r].exp_left), $sformatf("row %0d left", r));
        check_equal(got_right, $signed(rows[r].exp_right), $sformatf("row %0d right", r));
        read_reg(reg_status, rd);
        check_equal(rd, {6'b0, rows[r].control[0], rows[r].clip},
                    $sformatf("row %0d status", r));
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [7:0]  rd;
        logic [31:0] rng;
        reset = 1'b1;
        spi_cs_n = 1'b1;
        spi_clk = 1'b0;
        spi_mosi = 1'b0;
        src_left = 16'sd12345;
        src_right = -16'sd2222;
        rng = 32'd23032;

        // control, gains, inputs, expected outputs, expected clip
        rows[0] = '{8'h00, 8'd128, 8'd128, 16'sd5000, -16'sd5000, 16'sd0, 16'sd0, 1'b0};
        rows[1] = '{8'h01, 8'd128, 8'd128, 16'sd1000, -16'sd1000, 16'sd1000, -16'sd1000, 1'b0};
        rows[2] = '{8'h01, 8'd64, 8'd64, 16'sd12000, -16'sd12001, 16'sd6000, -16'sd6001, 1'b0};
        rows[3] = '{8'h01, 8'd192, 8'd32, 16'sd4000, -16'sd300, 16'sd6000, -16'sd75, 1'b0};
        rows[4] = '{8'h01, 8'd255, 8'd255, 16'sd20000, -16'sd20000,
                    16'sd32767, -16'sd32768, 1'b1};
        rows[5] = '{8'h01, 8'd255, 8'd128, 16'sd100, 16'sd32767, 16'sd199, 16'sd32767, 1'b0};
        rows[6] = '{8'h01, 8'd255, 8'd0, -16'sd32768, 16'sd1234, -16'sd32768, 16'sd0, 1'b1};
        // muted, then muted but disabled
        rows[7] = '{8'h03, 8'd255, 8'd255, 16'sd20000, -16'sd20000, 16'sd0, 16'sd0, 1'b0};
        rows[8] = '{8'h02, 8'd128, 8'd128, 16'sd1000, 16'sd1000, 16'sd0, 16'sd0, 1'b0};
        for (int k = n_fixed; k < n_rows; k++) begin
            rng = xorshift32(rng);
            rows[k].control = 8'h01;
            rows[k].gain_left = rng[7:0];
            rows[k].gain_right = rng[15:8];
            rng = xorshift32(rng);
            rows[k].in_left = rng[15:0];
            rows[k].in_right = rng[31:16];
            rows[k].exp_left = 16'(scaled_sample($signed(rows[k].in_left), rows[k].gain_left));
            rows[k].exp_right = 16'(scaled_sample($signed(rows[k].in_right),
                                                  rows[k].gain_right));
            rows[k].clip = clips($signed(rows[k].in_left), rows[k].gain_left)
                         | clips($signed(rows[k].in_right), rows[k].gain_right);
        end

        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // reset values, output silent while disabled
        read_reg(reg_control, rd);
        check_equal(rd, 0, "control after reset");
        read_reg(reg_gain_left, rd);
        check_equal(rd, unity_gain, "gain_left after reset");
        read_reg(reg_gain_right, rd);
        check_equal(rd, unity_gain, "gain_right after reset");
        read_reg(reg_id, rd);
        check_equal(rd, 8'ha5, "id register");
        wait_pairs(3);
        check_equal(got_left, 0, "left while disabled");
        check_equal(got_right, 0, "right while disabled");

        // round trip, read only and unknown addresses
        write_reg(reg_gain_left, 8'h5a);
        read_reg(reg_gain_left, rd);
        check_equal(rd, 8'h5a, "gain_left readback");
        write_reg(reg_gain_right, 8'h3c);
        read_reg(reg_gain_right, rd);
        check_equal(rd, 8'h3c, "gain_right readback");
        write_reg(reg_control, 8'h02);
        read_reg(reg_control, rd);
        check_equal(rd, 8'h02, "control readback");
        write_reg(reg_id, 8'h00);
        read_reg(reg_id, rd);
        check_equal(rd, 8'ha5, "id after write");
        write_reg(7'd7, 8'hff);
        read_reg(7'd7, rd);
        check_equal(rd, 0, "unknown address");

        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end

        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== hw/audipus_core.sv ====
`timescale 1ns/1ps

module audipus_core (
    input  logic clk,
    input  logic reset,
    // host spi
    input  logic spi_cs_n,
    input  logic spi_clk,
    input  logic spi_mosi,
    output logic spi_miso,
    // i2s from receiver chip
    input  logic i2s_bclk,
    input  logic i2s_lrclk,
    input  logic i2s_d,
    // i2s to dac
    output logic dac_bclk,
    output logic dac_lrclk,
    output logic dac_data
);
    import audio_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // connections
    //////////////////////////////////////////////////////////////////////

    audio_ctrl_if ctrl_if ();

    logic signed [sample_width-1:0] rx_left;
    logic signed [sample_width-1:0] rx_right;
    logic                           rx_valid;
    logic signed [sample_width-1:0] proc_left;
    logic signed [sample_width-1:0] proc_right;
    logic                           proc_valid;
    // synced clocks shared by rx and tx
    logic                           bclk_sync;
    logic                           lrclk_sync;
    logic                           bclk_fall;

    //////////////////////////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////////////////////////

    spi_reg_decode spi_reg_decode_i (
        .clk      (clk),
        .reset    (reset),
        .spi_cs_n (spi_cs_n),
        .spi_clk  (spi_clk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .ctrl     (ctrl_if.reg_side)
    );

    i2s_rx i2s_rx_i (
        .clk        (clk),
        .reset      (reset),
        .bclk       (i2s_bclk),
        .lrclk      (i2s_lrclk),
        .sdata      (i2s_d),
        .left       (rx_left),
        .right      (rx_right),
        .valid      (rx_valid),
        .bclk_sync  (bclk_sync),
        .lrclk_sync (lrclk_sync),
        .bclk_fall  (bclk_fall)
    );

    gain_stage gain_stage_i (
        .clk       (clk),
        .reset     (reset),
        .in_left   (rx_left),
        .in_right  (rx_right),
        .in_valid  (rx_valid),
        .out_left  (proc_left),
        .out_right (proc_right),
        .out_valid (proc_valid),
        .ctrl      (ctrl_if.audio_side)
    );

    i2s_tx i2s_tx_i (
        .clk        (clk),
        .reset      (reset),
        .left       (proc_left),
        .right      (proc_right),
        .valid      (proc_valid),
        .bclk_sync  (bclk_sync),
        .lrclk_sync (lrclk_sync),
        .bclk_fall  (bclk_fall),
        .dac_bclk   (dac_bclk),
        .dac_lrclk  (dac_lrclk),
        .dac_data   (dac_data)
    );

endmodule

// ==== hw/i2s_tx.sv ====
`timescale 1ns/1ps

module i2s_tx (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic signed [audio_pkg::sample_width-1:0] left,
    input  logic signed [audio_pkg::sample_width-1:0] right,
    input  logic                                      valid,
    input  logic                                      bclk_sync,
    input  logic                                      lrclk_sync,
    input  logic                                      bclk_fall,
    output logic                                      dac_bclk,
    output logic                                      dac_lrclk,
    output logic                                      dac_data
);
    import audio_pkg::*;

    // left word in the upper half
    logic [2*sample_width-1:0] frame_sr;
    logic                      lr_last;
    logic                      load_pend;
    logic                      load;

    // pair arrives inside the first bclk of the left channel
    assign load = valid & load_pend;

    //////////////////////////////////////////////////////////////////////
    // shift out on falling bclk
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_sr  <= '0;
            lr_last   <= 1'b0;
            load_pend <= 1'b0;
            dac_data  <= 1'b0;
        end else begin
            if (bclk_fall) begin
                lr_last  <= lrclk_sync;
                // lsb of the last word goes out on the lr edge itself
                dac_data <= frame_sr[2*sample_width-1];
                frame_sr <= frame_sr << 1;
                // left start window closes at the next fall
                load_pend <= lr_last & ~lrclk_sync;
            end else if (load) begin
                frame_sr  <= {left, right};
                load_pend <= 1'b0;
            end
        end
    end

    // forwarded clocks
    assign dac_bclk  = bclk_sync;
    assign dac_lrclk = lrclk_sync;

    // rx to gain latency must fit before the msb fall
    load_not_on_shift: assert property (@(posedge clk) disable iff (reset)
        !(load && bclk_fall));

endmodule

// ==== hw/gain_stage.sv ====
`timescale 1ns/1ps

module gain_stage (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic signed [audio_pkg::sample_width-1:0] in_left,
    input  logic signed [audio_pkg::sample_width-1:0] in_right,
    input  logic                                      in_valid,
    output logic signed [audio_pkg::sample_width-1:0] out_left,
    output logic signed [audio_pkg::sample_width-1:0] out_right,
    output logic                                      out_valid,
    audio_ctrl_if.audio_side                          ctrl
);
    import audio_pkg::*;

    logic                  active;
    // msb flags saturation
    logic [sample_width:0] scaled_left;
    logic [sample_width:0] scaled_right;

    // sample times q1.7 gain, then clamp
    function automatic logic [sample_width:0] scale(
        input logic signed [sample_width-1:0] s,
        input logic        [reg_width-1:0]    g
    );
        logic signed [sample_width+reg_width:0] prod;
        prod = s * $signed({1'b0, g});
        prod = prod >>> gain_frac;
        if (prod > sample_max) begin
            return {1'b1, sample_max};
        end else if (prod < sample_min) begin
            return {1'b1, sample_min};
        end
        return {1'b0, prod[sample_width-1:0]};
    endfunction

    assign active       = ctrl.enable & ~ctrl.mute;
    assign scaled_left  = scale(in_left, ctrl.gain_left);
    assign scaled_right = scale(in_right, ctrl.gain_right);

    //////////////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            ctrl.clip <= 1'b0;
        end else begin
            out_valid <= in_valid;
            // muted or disabled never counts as clipping
            ctrl.clip <= in_valid & active
                       & (scaled_left[sample_width] | scaled_right[sample_width]);
        end
    end

    // zeros out when muted or disabled
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_left  <= active ? scaled_left[sample_width-1:0] : '0;
            out_right <= active ? scaled_right[sample_width-1:0] : '0;
        end
    end

    // one pair per i2s frame upstream
    single_valid: assert property (@(posedge clk) disable iff (reset)
        out_valid |=> !out_valid);

endmodule

// ==== hw/i2s_rx.sv ====
`timescale 1ns/1ps

module i2s_rx (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   bclk,
    input  logic                                   lrclk,
    input  logic                                   sdata,
    output logic signed [audio_pkg::sample_width-1:0] left,
    output logic signed [audio_pkg::sample_width-1:0] right,
    output logic                                   valid,
    output logic                                   bclk_sync,
    output logic                                   lrclk_sync,
    output logic                                   bclk_fall
);
    import audio_pkg::*;

    // same depth on clocks and data keeps them aligned
    logic [2:0] bclk_q;
    logic [1:0] lrclk_q;
    logic [1:0] sdata_q;
    logic       bclk_rise;
    logic       lr_last;
    logic       lr_edge;
    logic       pair_done;

    logic [sample_width-1:0] shift_sr;
    logic [sample_width-1:0] word;

    always_ff @(posedge clk) begin
        if (reset) begin
            bclk_q  <= '0;
            lrclk_q <= '0;
            sdata_q <= '0;
        end else begin
            bclk_q  <= {bclk_q[1:0], bclk};
            lrclk_q <= {lrclk_q[0], lrclk};
            sdata_q <= {sdata_q[0], sdata};
        end
    end

    assign bclk_sync  = bclk_q[1];
    assign lrclk_sync = lrclk_q[1];
    assign bclk_rise  = bclk_q[1] & ~bclk_q[2];
    assign bclk_fall  = ~bclk_q[1] & bclk_q[2];

    // word including the bit sampled now
    assign word = {shift_sr[sample_width-2:0], sdata_q[1]};
    // one bclk delay, so the lsb lands on the first rise after the lr edge
    assign lr_edge = lrclk_sync != lr_last;

    //////////////////////////////////////////////////////////////////////
    // channel tracking and valid
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            lr_last   <= 1'b0;
            pair_done <= 1'b0;
            valid     <= 1'b0;
        end else begin
            pair_done <= 1'b0;
            valid     <= pair_done;
            if (bclk_rise) begin
                lr_last <= lrclk_sync;
                // high lr before the edge means right word done
                if (lr_edge && lr_last) begin
                    pair_done <= 1'b1;
                end
            end
        end
    end

    // sample shift and word latches
    always_ff @(posedge clk) begin
        if (bclk_rise) begin
            shift_sr <= word;
            if (lr_edge) begin
                if (lr_last) begin
                    right <= word;
                end else begin
                    left <= word;
                end
            end
        end
    end

endmodule

// ==== hw/spi_reg_decode.sv ====
`timescale 1ns/1ps

module spi_reg_decode (
    input  logic           clk,
    input  logic           reset,
    input  logic           spi_cs_n,
    input  logic           spi_clk,
    input  logic           spi_mosi,
    output logic           spi_miso,
    audio_ctrl_if.reg_side ctrl
);
    import audio_pkg::*;

    // sync chains, third stage only for edge detect
    logic [2:0] sclk_q;
    logic [2:0] cs_q;
    logic [1:0] mosi_q;
    logic       cs_sync;
    logic       cs_fall;
    logic       sclk_rise;
    logic       sclk_fall;

    spi_state_e             state;
    logic [3:0]             bit_cnt;
    logic [frame_width-1:0] frame_sr;
    logic [frame_width-1:0] frame_next;
    logic [reg_width-1:0]   rd_data;
    logic [reg_width-1:0]   rd_shift;
    logic                   frame_done;

    // write port of the bank
    logic                  wr_en;
    logic [addr_width-1:0] wr_addr;
    logic [reg_width-1:0]  wr_data;

    // register bank
    logic [reg_width-1:0] control_q;
    logic [reg_width-1:0] gain_left_q;
    logic [reg_width-1:0] gain_right_q;
    logic                 clip_flag;

    //////////////////////////////////////////////////////////////////////
    // pin sync and edges
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            sclk_q <= '0;
            cs_q   <= '1;
            mosi_q <= '0;
        end else begin
            sclk_q <= {sclk_q[1:0], spi_clk};
            cs_q   <= {cs_q[1:0], spi_cs_n};
            mosi_q <= {mosi_q[0], spi_mosi};
        end
    end

    assign cs_sync   = cs_q[1];
    assign cs_fall   = ~cs_q[1] & cs_q[2];
    assign sclk_rise = sclk_q[1] & ~sclk_q[2];
    assign sclk_fall = ~sclk_q[1] & sclk_q[2];

    // frame as it stands after the current bit
    assign frame_next = {frame_sr[frame_width-2:0], mosi_q[1]};

    //////////////////////////////////////////////////////////////////////
    // frame fsm
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            bit_cnt    <= '0;
            frame_done <= 1'b0;
            spi_miso   <= 1'b0;
            rd_shift   <= '0;
        end else begin
            frame_done <= 1'b0;
            if (cs_sync) begin
                // deselect drops any partial frame
                state    <= st_idle;
                bit_cnt  <= '0;
                spi_miso <= 1'b0;
            end else begin
                case (state)
                    st_idle: begin
                        spi_miso <= 1'b0;
                        if (cs_fall) begin
                            state   <= st_header;
                            bit_cnt <= '0;
                        end
                    end
                    st_header: begin
                        if (sclk_rise) begin
                            bit_cnt <= bit_cnt + 4'd1;
                            // opcode and address complete after 8 bits
                            if (bit_cnt == 4'd7) begin
                                state <= st_data;
                                if (spi_op_e'(frame_next[addr_width]) == op_read) begin
                                    rd_shift <= rd_data;
                                end else begin
                                    rd_shift <= '0;
                                end
                            end
                        end
                    end
                    st_data: begin
                        if (sclk_rise) begin
                            bit_cnt <= bit_cnt + 4'd1;
                            if (bit_cnt == 4'(frame_width - 1)) begin
                                frame_done <= 1'b1;
                                state      <= st_idle;
                            end
                        end
                        // mode 0, next bit out after the falling edge
                        if (sclk_fall) begin
                            spi_miso <= rd_shift[reg_width-1];
                            rd_shift <= rd_shift << 1;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // msb first shift
    always_ff @(posedge clk) begin
        if (sclk_rise && (state == st_header || state == st_data)) begin
            frame_sr <= frame_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // decode and register bank
    //////////////////////////////////////////////////////////////////////

    // read mux on the address just shifted in
    always_comb begin
        case (reg_addr_e'(frame_next[addr_width-1:0]))
            reg_control:    rd_data = control_q;
            reg_gain_left:  rd_data = gain_left_q;
            reg_gain_right: rd_data = gain_right_q;
            reg_status:     rd_data = {{(reg_width-2){1'b0}}, control_q[0], clip_flag};
            reg_id:         rd_data = id_value;
            default:        rd_data = '0;
        endcase
    end

    // decode stage between frame end and bank update
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= frame_done && (spi_op_e'(frame_sr[frame_width-1]) == op_write);
        end
        wr_addr <= frame_sr[frame_width-2 -: addr_width];
        wr_data <= frame_sr[reg_width-1:0];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            control_q    <= '0;
            gain_left_q  <= unity_gain;
            gain_right_q <= unity_gain;
            clip_flag    <= 1'b0;
        end else begin
            if (wr_en) begin
                case (reg_addr_e'(wr_addr))
                    reg_control: begin
                        control_q <= wr_data;
                        clip_flag <= 1'b0;
                    end
                    reg_gain_left:  gain_left_q  <= wr_data;
                    reg_gain_right: gain_right_q <= wr_data;
                    // status, id and holes stay untouched
                    default: ;
                endcase
            end
            // new clip event wins over a clear
            if (ctrl.clip) begin
                clip_flag <= 1'b1;
            end
        end
    end

    assign ctrl.enable     = control_q[0];
    assign ctrl.mute       = control_q[1];
    assign ctrl.gain_left  = gain_left_q;
    assign ctrl.gain_right = gain_right_q;

    // bank update lands before the host can deselect
    wr_inside_frame: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> !cs_sync);

endmodule

// ==== hw/audio_ctrl_if.sv ====
`timescale 1ns/1ps

interface audio_ctrl_if;
    import audio_pkg::*;

    // control register fields
    logic                 enable;
    logic                 mute;
    logic [reg_width-1:0] gain_left;
    logic [reg_width-1:0] gain_right;
    // one pulse per clipped sample pair
    logic                 clip;

    // register bank side
    modport reg_side (
        output enable, mute, gain_left, gain_right,
        input  clip
    );

    // audio path side
    modport audio_side (
        input  enable, mute, gain_left, gain_right,
        output clip
    );

endinterface

// ==== hw/audio_pkg.sv ====
package audio_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    // audio samples, two's complement
    localparam int sample_width = 16;
    // spi register bank
    localparam int reg_width  = 8;
    localparam int addr_width = 7;
    // opcode + address + data
    localparam int frame_width = 1 + addr_width + reg_width;

    //////////////////////////////////////////////////////////////////////
    // gain and saturation
    //////////////////////////////////////////////////////////////////////

    // gain is unsigned q1.7, 128 is x1.0
    localparam logic [reg_width-1:0] unity_gain = 8'd128;
    localparam int gain_frac = 7;
    localparam logic signed [sample_width-1:0] sample_max = 16'sh7fff;
    localparam logic signed [sample_width-1:0] sample_min = 16'sh8000;

    // fixed value of the id register
    localparam logic [reg_width-1:0] id_value = 8'ha5;

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [addr_width-1:0] {
        reg_control    = 7'd0,
        reg_gain_left  = 7'd1,
        reg_gain_right = 7'd2,
        reg_status     = 7'd3,
        reg_id         = 7'd4
    } reg_addr_e;

    // frame bit 15
    typedef enum logic {
        op_write = 1'b0,
        op_read  = 1'b1
    } spi_op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_header,
        st_data
    } spi_state_e;

endpackage
